//--- verilog.f
src/core_pkg.sv
src/rf_read_if.sv
src/regfile.sv
src/idu.sv
src/id_ex.sv
src/exu.sv
src/core_top.sv
bench/tb_properties.sv
bench/tb_top.sv

//--- Makefile
# Verilator build and run of the RV32 core slice testbench

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_top \
		-f verilog.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/tb_top.sv
/*
 * testbench for core_top, table of instructions with expected writeback
 * LFSR chosen bubble cycles, stall and writeback checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import core_pkg::*;
();

    localparam int MAX_ROWS   = 32;
    localparam int STALL_WAIT = 64;                // cycles before giving up on stall_o

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  inst_valid_i;
    logic [XLEN-1:0]       inst_i;
    logic [XLEN-1:0]       inst_addr_i;
    logic                  stall_o;
    logic                  wb_we_o;
    logic [REG_ADDR_W-1:0] wb_addr_o;
    logic [XLEN-1:0]       wb_data_o;

    logic [XLEN-1:0]       t_inst [MAX_ROWS];      // instruction word
    logic                  t_we   [MAX_ROWS];      // writeback expected
    logic [REG_ADDR_W-1:0] t_rd   [MAX_ROWS];
    logic [XLEN-1:0]       t_val  [MAX_ROWS];      // expected rd value
    int                    n_rows;
    int                    errors;

    core_top u_core_top (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .stall_o      (stall_o),
        .wb_we_o      (wb_we_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    bind core_top tb_properties u_props (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall_o),
        .wb_we_i   (wb_we_o),
        .wb_addr_i (wb_addr_o)
    );

    always #50 clk_i = ~clk_i;                     // 100 ns period

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // x16 + x14 + x13 + x11 feedback
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic bit is_mul(input logic [31:0] inst);
        return (inst[6:0] == 7'b0110011) && (inst[31:25] == 7'b0000001);
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic we,
                           input logic [4:0] rd, input logic [31:0] val);
        t_inst[n_rows] = inst;
        t_we[n_rows]   = we;
        t_rd[n_rows]   = rd;
        t_val[n_rows]  = val;
        n_rows++;
    endtask

    task automatic build_table();
        add_row(i_type(12'd5, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'd5);        // addi
        add_row(i_type(12'd7, 5'd1, 3'b000, 5'd2), 1'b1, 5'd2, 32'd12);       // bypass chain
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'd17); // add
        add_row(r_type(7'h20, 5'd3, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'hFFFF_FFF4);
        add_row(r_type(7'h00, 5'd1, 5'd4, 3'b010, 5'd5), 1'b1, 5'd5, 32'd1);  // signed slt
        add_row(r_type(7'h00, 5'd4, 5'd2, 3'b100, 5'd6), 1'b1, 5'd6, 32'hFFFF_FFF8);
        add_row(r_type(7'h00, 5'd4, 5'd2, 3'b110, 5'd7), 1'b1, 5'd7, 32'hFFFF_FFFC);
        add_row(r_type(7'h00, 5'd4, 5'd2, 3'b111, 5'd8), 1'b1, 5'd8, 32'h4);
        add_row(r_type(7'h00, 5'd4, 5'd1, 3'b001, 5'd9), 1'b1, 5'd9, 32'h0050_0000);
        add_row(r_type(7'h00, 5'd1, 5'd4, 3'b101, 5'd10), 1'b1, 5'd10, 32'h07FF_FFFF);
        add_row(i_type(12'h0F0, 5'd4, 3'b111, 5'd11), 1'b1, 5'd11, 32'hF0);
        add_row(i_type(12'hF00, 5'd1, 3'b110, 5'd12), 1'b1, 5'd12, 32'hFFFF_FF05);
        add_row(i_type(12'h7FF, 5'd3, 3'b100, 5'd13), 1'b1, 5'd13, 32'h7EE);
        add_row(u_type(20'hABCDE, 5'd14, 7'b0110111), 1'b1, 5'd14, 32'hABCD_E000);
        add_row(u_type(20'h00012, 5'd15, 7'b0010111), 1'b1, 5'd15, 32'h0001_3038);
        add_row(i_type(12'd9, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'h0);        // rd x0
        add_row(i_type(12'h123, 5'd0, 3'b000, 5'd16), 1'b1, 5'd16, 32'h123);
        add_row(r_type(7'h01, 5'd3, 5'd2, 3'b000, 5'd17), 1'b1, 5'd17, 32'hCC); // mul
        add_row(r_type(7'h00, 5'd1, 5'd17, 3'b000, 5'd18), 1'b1, 5'd18, 32'hD1);
        add_row(r_type(7'h01, 5'd4, 5'd4, 3'b000, 5'd19), 1'b1, 5'd19, 32'h90);
        add_row(r_type(7'h20, 5'd2, 5'd19, 3'b000, 5'd20), 1'b1, 5'd20, 32'h84);
    endtask

    initial begin
        logic [15:0] lfsr;
        logic        held;
        int          stall_cnt;
        int          exp_stall;
        int          row_err;
        int          bubbles;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        errors       = 0;
        bubbles      = 0;
        n_rows       = 0;
        held         = 1'b0;
        lfsr         = 16'd50506;
        build_table();

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        assert (!stall_o && !wb_we_o) else begin
            $display("stall_o or wb_we_o high after reset with no instruction");
            errors++;
        end

        for (int i = 0; i < n_rows; i++) begin
            row_err = 0;
            if (!held) begin
                lfsr = lfsr_step(lfsr);
                if (lfsr[0]) begin
                    inst_valid_i = 1'b0;           // bubble cycle first
                    bubbles++;
                    @(negedge clk_i);
                    assert (!wb_we_o) else begin
                        $display("writeback seen after a bubble in test %0d", i);
                        row_err++;
                    end
                end
                inst_valid_i = 1'b1;
                inst_i       = t_inst[i];
                inst_addr_i  = 32'h1000 + 4 * i;
            end
            held = 1'b0;
            @(negedge clk_i);
            if (stall_o && (i + 1 < n_rows)) begin
                inst_i      = t_inst[i+1];         // next one waits behind the busy unit
                inst_addr_i = 32'h1000 + 4 * (i + 1);
                held        = 1'b1;
            end
            stall_cnt = 0;
            while (stall_o && stall_cnt < STALL_WAIT) begin
                @(negedge clk_i);
                stall_cnt++;
            end
            if (stall_o) begin
                $display("timeout, stall_o stuck high in test %0d", i);
                $display("Something failed");
                $finish;
            end
            exp_stall = is_mul(t_inst[i]) ? 32 : 0;
            assert (stall_cnt == exp_stall) else begin
                $display("stall lasted %0d cycles, expected %0d in test %0d",
                         stall_cnt, exp_stall, i);
                row_err++;
            end
            assert (wb_we_o == t_we[i]) else begin
                $display("[FAIL] wb_we_o got %h expected %h", wb_we_o, t_we[i]);
                row_err++;
            end
            if (t_we[i]) begin
                assert (wb_addr_o == t_rd[i]) else begin
                    $display("[FAIL] wb_addr_o got %h expected %h", wb_addr_o, t_rd[i]);
                    row_err++;
                end
                assert (wb_data_o == t_val[i]) else begin
                    $display("[FAIL] wb_data_o got %h expected %h", wb_data_o, t_val[i]);
                    row_err++;
                end
            end
            $display("test %0d inst %h %s", i, t_inst[i], (row_err == 0) ? "ok" : "error");
            errors += row_err;
        end

        inst_valid_i = 1'b0;
        @(negedge clk_i);
        $display("%0d tests, %0d bubbles, %0d errors", n_rows, bubbles, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_properties.sv
/*
 * concurrent checks on the core_top ports
 * reset quiet, no x0 writeback, stall and writeback exclusive
 */
`timescale 1ns/1ps
`default_nettype none

module tb_properties
    import core_pkg::*;
(
    input wire logic                  clk_i,
    input wire logic                  rst_n_i,
    input wire logic                  stall_i,
    input wire logic                  wb_we_i,
    input wire logic [REG_ADDR_W-1:0] wb_addr_i
);

    // outputs quiet while reset is held
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> (!stall_i && !wb_we_i))
        else $error("stall_o or wb_we_o high during reset");

    no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_we_i |-> (wb_addr_i != '0))
        else $error("writeback to x0");

    // mul writes only after busy drops
    stall_wb_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(wb_we_i && stall_i))
        else $error("wb_we_o and stall_o high together");

endmodule

`default_nettype wire

//--- src/core_top.sv
/*
 * RV32 core slice top level
 * decoder, id_ex stage, execute unit and register file
 */
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  inst_valid_i,   // instruction offered
    input  wire logic [XLEN-1:0]       inst_i,         // instruction word
    input  wire logic [XLEN-1:0]       inst_addr_i,    // instruction pc
    output logic                       stall_o,        // fetcher must hold
    output logic                       wb_we_o,        // writeback mirror
    output logic [REG_ADDR_W-1:0]      wb_addr_o,
    output logic [XLEN-1:0]            wb_data_o
);

    ex_req_t dec_req;                              // decode output
    ex_req_t ex_req;                               // registered request

    rf_read_if u_rf_if ();                         // decode to regfile reads

    idu u_idu (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .rf           (u_rf_if.reader),
        .req_o        (dec_req)
    );

    id_ex u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .hold_i  (stall_o),                        // busy freezes the stage
        .req_i   (dec_req),
        .req_o   (ex_req)
    );

    exu u_exu (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (ex_req),
        .busy_o    (stall_o),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    regfile u_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .rd        (u_rf_if.owner),
        .wb_we_i   (wb_we_o),                      // writeback also feeds the bypass
        .wb_addr_i (wb_addr_o),
        .wb_data_i (wb_data_o)
    );

endmodule

`default_nettype wire

//--- src/exu.sv
/*
 * execute unit, single-cycle ALU and 32-step shift-add multiplier
 * drives the register file writeback and the busy back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module exu
    import core_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  ex_req_t                    req_i,      // request from id_ex
    output logic                       busy_o,     // mul in progress
    output logic                       wb_we_o,    // writeback enable
    output logic [REG_ADDR_W-1:0]      wb_addr_o,  // writeback index
    output logic [XLEN-1:0]            wb_data_o   // writeback value
);

    localparam logic [5:0] MUL_LAST = 6'd32;       // steps of the multiplier

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            is_mul;                       // valid mul in execute
    logic            mul_done;                     // all 32 steps taken
    logic [5:0]      mul_cnt;                      // steps taken so far
    logic [XLEN-1:0] mul_acc;                      // running low product
    logic [XLEN-1:0] mul_part;                     // partial product this step

    assign op_a = req_i.rs1_data;
    assign op_b = req_i.use_imm ? req_i.imm : req_i.rs2_data;

    always_comb begin
        unique case (req_i.alu_op)
            op_add:   alu_res = op_a + op_b;
            op_sub:   alu_res = op_a - op_b;
            op_and:   alu_res = op_a & op_b;
            op_or:    alu_res = op_a | op_b;
            op_xor:   alu_res = op_a ^ op_b;
            op_sll:   alu_res = op_a << op_b[4:0];           // low 5 bits only
            op_srl:   alu_res = op_a >> op_b[4:0];
            op_slt:   alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            op_lui:   alu_res = req_i.imm;
            op_auipc: alu_res = req_i.inst_addr + req_i.imm;
            default:  alu_res = '0;                          // mul result comes from acc
        endcase
    end

    assign is_mul   = req_i.valid && (req_i.alu_op == op_mul);
    assign mul_done = (mul_cnt == MUL_LAST);
    assign busy_o   = is_mul && !mul_done;         // high for 32 cycles per mul

    // one multiplier bit per cycle, operands stay put since id_ex holds
    assign mul_part = op_b[mul_cnt[4:0]] ? (op_a << mul_cnt[4:0]) : '0;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mul_cnt <= '0;
        end else if (busy_o) begin
            mul_cnt <= mul_cnt + 6'd1;             // next step
        end else begin
            mul_cnt <= '0;                         // ready for the next mul
        end
    end

    always_ff @(posedge clk_i) begin
        if (busy_o) begin
            mul_acc <= ((mul_cnt == '0) ? '0 : mul_acc) + mul_part;  // first step restarts
        end
    end

    // mul writes only once, on the cycle after its last step
    assign wb_we_o   = req_i.valid && req_i.reg_we && (!is_mul || mul_done);
    assign wb_addr_o = req_i.rd;
    assign wb_data_o = is_mul ? mul_acc : alu_res;

endmodule

`default_nettype wire

//--- src/id_ex.sv
/*
 * decode-to-execute pipeline register
 * freezes while execute is busy, resets to a bubble
 */
`timescale 1ns/1ps
`default_nettype none

module id_ex
    import core_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_n_i,
    input  wire logic hold_i,                      // execute busy, keep content
    input  ex_req_t   req_i,                       // request from decode
    output ex_req_t   req_o                        // request seen by execute
);

    ex_req_t req_q;                                // the single stage

    // the whole request moves as one word, so
    // control bits and operands never get out of step
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q <= EX_BUBBLE;                    // valid low after reset
        end else if (!hold_i) begin
            req_q <= req_i;                        // advance one slot
        end
    end

    assign req_o = req_q;

endmodule

`default_nettype wire

//--- src/idu.sv
/*
 * instruction decoder, RV32 OP, OP-IMM, LUI and AUIPC subset plus MUL
 * reads operands from the register file and builds the execute request
 */
`timescale 1ns/1ps
`default_nettype none

module idu
    import core_pkg::*;
(
    input  wire logic            inst_valid_i, // fetcher presents an instruction
    input  wire logic [XLEN-1:0] inst_i,       // instruction word
    input  wire logic [XLEN-1:0] inst_addr_i,  // its pc
    rf_read_if.reader            rf,           // operand reads
    output ex_req_t              req_o         // request to id_ex
);

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd_idx;
    logic [XLEN-1:0]       imm_i;              // I-type, sign extended
    logic [XLEN-1:0]       imm_u;              // U-type, upper 20 bits
    logic                  legal;              // encoding is supported
    ex_req_t               req;

    assign opcode = inst_i[6:0];
    assign rd_idx = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {inst_i[31:12], 12'b0};

    // register indices come straight from the fields
    assign rf.raddr1 = inst_i[19:15];
    assign rf.raddr2 = inst_i[24:20];

    always_comb begin
        req           = EX_BUBBLE;
        legal         = 1'b1;
        req.rd        = rd_idx;
        req.rs1_data  = rf.rdata1;
        req.rs2_data  = rf.rdata2;
        req.inst_addr = inst_addr_i;
        unique case (opcode)
            OPC_OP: begin
                unique case ({funct7, funct3})
                    {7'b0000000, 3'b000}: req.alu_op = op_add;
                    {7'b0100000, 3'b000}: req.alu_op = op_sub;
                    {7'b0000000, 3'b001}: req.alu_op = op_sll;
                    {7'b0000000, 3'b010}: req.alu_op = op_slt;
                    {7'b0000000, 3'b100}: req.alu_op = op_xor;
                    {7'b0000000, 3'b101}: req.alu_op = op_srl;
                    {7'b0000000, 3'b110}: req.alu_op = op_or;
                    {7'b0000000, 3'b111}: req.alu_op = op_and;
                    {7'b0000001, 3'b000}: req.alu_op = op_mul;  // M extension, low half
                    default:              legal      = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                req.use_imm = 1'b1;
                req.imm     = imm_i;
                unique case (funct3)
                    3'b000:  req.alu_op = op_add;  // addi
                    3'b100:  req.alu_op = op_xor;  // xori
                    3'b110:  req.alu_op = op_or;   // ori
                    3'b111:  req.alu_op = op_and;  // andi
                    default: legal      = 1'b0;    // shifts and slti not in subset
                endcase
            end
            OPC_LUI: begin
                req.alu_op = op_lui;
                req.imm    = imm_u;
            end
            OPC_AUIPC: begin
                req.alu_op = op_auipc;
                req.imm    = imm_u;
            end
            default: legal = 1'b0;
        endcase
        req.valid  = 1'b1;
        req.reg_we = (rd_idx != '0);               // x0 never written
        if (!(inst_valid_i && legal)) begin
            req = EX_BUBBLE;                       // no instruction or unknown one
        end
    end

    assign req_o = req;

endmodule

`default_nettype wire

//--- src/regfile.sv
/*
 * 32 x 32 integer register file, x0 hardwired to zero
 * write at the clock edge, combinational reads with write-through bypass
 */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import core_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    rf_read_if.owner                   rd,         // read ports from decode
    input  wire logic                  wb_we_i,    // writeback enable
    input  wire logic [REG_ADDR_W-1:0] wb_addr_i,  // writeback index
    input  wire logic [XLEN-1:0]       wb_data_i   // writeback value
);

    logic [XLEN-1:0] regs [1:31];                  // x0 has no storage

    // same lookup for both read ports
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;                              // x0 always zero
        end else if (wb_we_i && (wb_addr_i == addr)) begin
            val = wb_data_i;                       // bypass the value being written
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                     // clear all at reset
            end
        end else if (wb_we_i && (wb_addr_i != '0)) begin
            regs[wb_addr_i] <= wb_data_i;          // writes to x0 dropped
        end
    end

    // reads follow the writeback and the stored values too
    always_comb begin
        rd.rdata1 = read_port(rd.raddr1);
        rd.rdata2 = read_port(rd.raddr2);
    end

endmodule

`default_nettype wire

//--- src/rf_read_if.sv
/*
 * two-port register file read interface
 */
`timescale 1ns/1ps
`default_nettype none

interface rf_read_if
    import core_pkg::*;
();

    logic [REG_ADDR_W-1:0] raddr1;                 // rs1 index
    logic [REG_ADDR_W-1:0] raddr2;                 // rs2 index
    logic [XLEN-1:0]       rdata1;                 // rs1 value, combinational
    logic [XLEN-1:0]       rdata2;                 // rs2 value, combinational

    modport reader (output raddr1, output raddr2, input rdata1, input rdata2);
    modport owner  (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

`default_nettype wire

//--- src/core_pkg.sv
/*
 * shared widths for the RV32 core slice
 * ALU operation enum, execute request struct and its bubble value
 */
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;                // data and address width
    localparam int REG_ADDR_W = 5;                 // register index width

    // operation carried from decode into execute
    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_and   = 4'd2,
        op_or    = 4'd3,
        op_xor   = 4'd4,
        op_sll   = 4'd5,
        op_srl   = 4'd6,
        op_slt   = 4'd7,                           // signed compare
        op_lui   = 4'd8,                           // result is the immediate
        op_auipc = 4'd9,                           // pc plus immediate
        op_mul   = 4'd10                           // multi-cycle, low 32 bits
    } alu_op_e;

    typedef struct packed {
        logic                  valid;              // slot holds an instruction
        alu_op_e               alu_op;             // operation to execute
        logic                  use_imm;            // imm replaces rs2 as operand b
        logic                  reg_we;             // write rd at the end
        logic [REG_ADDR_W-1:0] rd;                 // destination register
        logic [XLEN-1:0]       rs1_data;           // operand a
        logic [XLEN-1:0]       rs2_data;           // operand b, register form
        logic [XLEN-1:0]       imm;                // sign-extended or upper imm
        logic [XLEN-1:0]       inst_addr;          // pc of the instruction
    } ex_req_t;

    localparam ex_req_t EX_BUBBLE = '0;            // reset and bubble content

endpackage

`default_nettype wire
